// File: src/pu_bus_pkg.sv
`default_nettype none

// Layout of the attribute field that travels next to every data word on
// the shared bus. Only the invalid flag has a meaning today; the other
// bits are reserved and driven as zero by every unit.
package pu_bus_pkg;

    localparam int attr_width       = 4; // Attribute bits per bus word
    localparam int attr_invalid_bit = 0; // Set when the word must not be trusted

    typedef logic [attr_width-1:0] attr_t;

endpackage

`default_nettype wire

// File: src/pu_ctrl_pkg.sv
`default_nettype none

// Transfer program format for the sequencer
package pu_ctrl_pkg;

    typedef enum logic [2:0] {
        src_none  = 3'd0, // Bus stays at zero
        src_ext   = 3'd1, // External input port
        src_mult  = 3'd2,
        src_accum = 3'd3,
        src_fram  = 3'd4
    } src_e;

    typedef enum logic [2:0] {
        dst_none  = 3'd0, // Nobody takes the bus value
        dst_mult  = 3'd1,
        dst_accum = 3'd2,
        dst_fram  = 3'd3,
        dst_ext   = 3'd4  // Result output register
    } dst_e;

    typedef struct packed {
        src_e       src;
        dst_e       dst;
        logic       sel;  // Multiplier operand index, or add instead of load
        logic [1:0] addr; // Register bank word
        logic       last; // Final step of the program
    } instr_t;

    localparam int instr_width = $bits(instr_t);

endpackage

`default_nettype wire

// File: src/pu_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module pu_multiplier
    import pu_bus_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  signal_wr,
    input  wire logic                  signal_sel,
    input  wire logic [DATA_WIDTH-1:0] data_in,
    input  wire attr_t                 attr_in,
    input  wire logic                  signal_oe,
    output logic      [DATA_WIDTH-1:0] data_out,
    output attr_t                      attr_out
);

    localparam int HALF = DATA_WIDTH / 2;

    logic [DATA_WIDTH-1:0] arg [2];
    logic                  arg_inv [2];
    logic                  sel_q;           // Sel level one cycle back
    logic                  capture;         // Pulses one cycle after sel falls
    logic [DATA_WIDTH-1:0] product;
    logic                  product_inv;
    logic [DATA_WIDTH-1:0] result;
    logic                  result_inv;
    attr_t                 result_attr;

    // An operand fits when its upper half and the sign bit of its lower
    // half are all the same value
    function automatic logic fits_half(input logic [DATA_WIDTH-1:0] value);
        logic [HALF:0] top;
        top = value[DATA_WIDTH-1:HALF-1];
        return (&top) || !(|top);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            arg[0]     <= '0;
            arg[1]     <= '0;
            arg_inv[0] <= 1'b0;
            arg_inv[1] <= 1'b0;
        end else if (signal_wr) begin
            arg[signal_sel]     <= data_in;
            arg_inv[signal_sel] <= attr_in[attr_invalid_bit];
        end
    end

    assign product = $signed(arg[0][HALF-1:0]) * $signed(arg[1][HALF-1:0]);
    assign product_inv = !fits_half(arg[0]) || !fits_half(arg[1])
                         || arg_inv[0] || arg_inv[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q   <= 1'b0;
            capture <= 1'b0;
        end else begin
            sel_q   <= signal_sel;
            capture <= sel_q && !signal_sel; // Falling edge of sel
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result     <= '0;
            result_inv <= 1'b0;
        end else if (capture) begin
            result     <= product;
            result_inv <= product_inv;
        end
    end

    always_comb begin
        result_attr                   = '0;
        result_attr[attr_invalid_bit] = result_inv;
    end

    assign data_out = signal_oe ? result : '0;
    assign attr_out = signal_oe ? result_attr : '0;

    // An unknown strobe would silently corrupt an operand
    a_wr_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(signal_wr));

endmodule

`default_nettype wire

// File: src/pu_accum.sv
`timescale 1ns/1ps
`default_nettype none

module pu_accum
    import pu_bus_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  signal_wr,
    input  wire logic                  signal_sel,
    input  wire logic [DATA_WIDTH-1:0] data_in,
    input  wire attr_t                 attr_in,
    input  wire logic                  signal_oe,
    output logic      [DATA_WIDTH-1:0] data_out,
    output attr_t                      attr_out
);

    logic [DATA_WIDTH-1:0] acc;
    logic                  acc_inv;
    logic [DATA_WIDTH-1:0] sum;
    logic                  overflow;
    attr_t                 acc_attr;

    assign sum = acc + data_in;

    // Signed overflow when both addends share a sign and the sum does not
    assign overflow = (acc[DATA_WIDTH-1] == data_in[DATA_WIDTH-1])
                      && (sum[DATA_WIDTH-1] != acc[DATA_WIDTH-1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc     <= '0;
            acc_inv <= 1'b0;
        end else if (signal_wr) begin
            if (signal_sel) begin
                acc     <= sum;
                acc_inv <= acc_inv || overflow || attr_in[attr_invalid_bit]; // Sticky
            end else begin
                acc     <= data_in;
                acc_inv <= attr_in[attr_invalid_bit];
            end
        end
    end

    always_comb begin
        acc_attr                   = '0;
        acc_attr[attr_invalid_bit] = acc_inv;
    end

    assign data_out = signal_oe ? acc : '0;
    assign attr_out = signal_oe ? acc_attr : '0;

endmodule

`default_nettype wire

// File: src/pu_fram.sv
`timescale 1ns/1ps
`default_nettype none

module pu_fram
    import pu_bus_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  signal_wr,
    input  wire logic [1:0]            signal_addr,
    input  wire logic [DATA_WIDTH-1:0] data_in,
    input  wire attr_t                 attr_in,
    input  wire logic                  signal_oe,
    output logic      [DATA_WIDTH-1:0] data_out,
    output attr_t                      attr_out
);

    logic [DATA_WIDTH-1:0] words [4];
    attr_t                 attrs [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                words[i] <= '0;
                attrs[i] <= '0;
            end
        end else if (signal_wr) begin
            words[signal_addr] <= data_in;
            attrs[signal_addr] <= attr_in; // Whole field kept, not just the invalid flag
        end
    end

    assign data_out = signal_oe ? words[signal_addr] : '0;
    assign attr_out = signal_oe ? attrs[signal_addr] : '0;

endmodule

`default_nettype wire

// File: src/pu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pu_sequencer
    import pu_ctrl_pkg::*;
#(
    parameter int PROG_DEPTH = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          prog_we,
    input  wire logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  wire logic [instr_width-1:0]        prog_data,
    input  wire logic                          start,
    output logic                               in_take,
    output logic                               ext_oe,
    output logic                               mult_oe,
    output logic                               accum_oe,
    output logic                               fram_oe,
    output logic                               mult_wr,
    output logic                               mult_sel,
    output logic                               accum_wr,
    output logic                               accum_sel,
    output logic                               fram_wr,
    output logic [1:0]                         fram_addr,
    output logic                               out_capture,
    output logic                               busy,
    output logic                               done
);

    localparam int PC_WIDTH = $clog2(PROG_DEPTH);

    instr_t                prog_mem [PROG_DEPTH];
    instr_t                cur;
    logic   [PC_WIDTH-1:0] pc;
    logic                  mult_sel_q;
    logic                  accum_sel_q;
    logic   [1:0]          fram_addr_q;

    // Program loads are ignored while a run is in progress
    always_ff @(posedge clk) begin
        if (prog_we && !busy) begin
            prog_mem[prog_addr] <= instr_t'(prog_data);
        end
    end

    assign cur = prog_mem[pc];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= busy && cur.last;
            if (!busy) begin
                if (start) begin
                    pc   <= '0;
                    busy <= 1'b1;
                end
            end else if (cur.last) begin
                busy <= 1'b0;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // One source enable per step
    assign ext_oe   = busy && (cur.src == src_ext);
    assign mult_oe  = busy && (cur.src == src_mult);
    assign accum_oe = busy && (cur.src == src_accum);
    assign fram_oe  = busy && (cur.src == src_fram);
    assign in_take  = ext_oe;

    assign mult_wr     = busy && (cur.dst == dst_mult);
    assign accum_wr    = busy && (cur.dst == dst_accum);
    assign fram_wr     = busy && (cur.dst == dst_fram);
    assign out_capture = busy && (cur.dst == dst_ext);

    // Sel levels follow the step that writes the unit and hold otherwise
    assign mult_sel  = mult_wr ? cur.sel : mult_sel_q;
    assign accum_sel = accum_wr ? cur.sel : accum_sel_q;
    assign fram_addr = (fram_wr || fram_oe) ? cur.addr : fram_addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mult_sel_q  <= 1'b0;
            accum_sel_q <= 1'b0;
            fram_addr_q <= '0;
        end else begin
            mult_sel_q  <= mult_sel;
            accum_sel_q <= accum_sel;
            fram_addr_q <= fram_addr;
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        !(start && busy));

endmodule

`default_nettype wire

// File: src/pu_net.sv
`timescale 1ns/1ps
`default_nettype none

module pu_net
    import pu_bus_pkg::*;
    import pu_ctrl_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int PROG_DEPTH = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          prog_we,
    input  wire logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  wire logic [instr_width-1:0]        prog_data,
    input  wire logic                          start,
    input  wire logic [DATA_WIDTH-1:0]         in_data,
    input  wire attr_t                         in_attr,
    output logic                               in_take,
    output logic                               out_valid,
    output logic      [DATA_WIDTH-1:0]         out_data,
    output attr_t                              out_attr,
    output logic                               busy,
    output logic                               done
);

    logic                  ext_oe, mult_oe, accum_oe, fram_oe;
    logic                  mult_wr, mult_sel, accum_wr, accum_sel, fram_wr;
    logic [1:0]            fram_addr;
    logic                  out_capture;
    logic [DATA_WIDTH-1:0] mult_data, accum_data, fram_data, bus_data;
    attr_t                 mult_attr, accum_attr, fram_attr, bus_attr;

    pu_sequencer #(
        .PROG_DEPTH(PROG_DEPTH)
    ) i_pu_sequencer (
        .clk, .rst, .prog_we, .prog_addr, .prog_data, .start, .in_take,
        .ext_oe, .mult_oe, .accum_oe, .fram_oe,
        .mult_wr, .mult_sel, .accum_wr, .accum_sel, .fram_wr, .fram_addr,
        .out_capture, .busy, .done
    );

    // Units drive zero unless enabled, so OR-ing them forms the bus
    assign bus_data = (ext_oe ? in_data : '0) | mult_data | accum_data | fram_data;
    assign bus_attr = (ext_oe ? in_attr : '0) | mult_attr | accum_attr | fram_attr;

    pu_multiplier #(.DATA_WIDTH(DATA_WIDTH)) i_pu_multiplier (
        .clk, .rst, .signal_wr(mult_wr), .signal_sel(mult_sel),
        .data_in(bus_data), .attr_in(bus_attr), .signal_oe(mult_oe),
        .data_out(mult_data), .attr_out(mult_attr)
    );

    pu_accum #(.DATA_WIDTH(DATA_WIDTH)) i_pu_accum (
        .clk, .rst, .signal_wr(accum_wr), .signal_sel(accum_sel),
        .data_in(bus_data), .attr_in(bus_attr), .signal_oe(accum_oe),
        .data_out(accum_data), .attr_out(accum_attr)
    );

    pu_fram #(.DATA_WIDTH(DATA_WIDTH)) i_pu_fram (
        .clk, .rst, .signal_wr(fram_wr), .signal_addr(fram_addr),
        .data_in(bus_data), .attr_in(bus_attr), .signal_oe(fram_oe),
        .data_out(fram_data), .attr_out(fram_attr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= out_capture;
        end
    end

    always_ff @(posedge clk) begin
        if (out_capture) begin
            out_data <= bus_data;
            out_attr <= bus_attr;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk; // First rising edge after half a period
    end

endmodule

`default_nettype wire

// File: test/pu_net_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pu_net_tb
    import pu_bus_pkg::*;
    import pu_ctrl_pkg::*;
();

    localparam int DATA_WIDTH  = 32;
    localparam int PROG_DEPTH  = 16;
    localparam int addr_width  = $clog2(PROG_DEPTH);
    localparam int half_width  = DATA_WIDTH / 2;
    localparam int random_runs = 20;
    localparam int mult_steps  = 5;
    localparam int accum_steps = 4;
    localparam int total_steps = mult_steps * (2 + 2 + random_runs) + accum_steps * 2;
    localparam int watchdog_ns = total_steps * 40 * 4;

    logic                   clk;
    logic                   rst;
    logic                   prog_we;
    logic [addr_width-1:0]  prog_addr;
    logic [instr_width-1:0] prog_data;
    logic                   start;
    logic [DATA_WIDTH-1:0]  in_data;
    attr_t                  in_attr;
    logic                   in_take;
    logic                   out_valid;
    logic [DATA_WIDTH-1:0]  out_data;
    attr_t                  out_attr;
    logic                   busy;
    logic                   done;

    instr_t                program_q [$];
    logic [DATA_WIDTH-1:0] in_data_q [$];
    attr_t                 in_attr_q [$];
    logic [DATA_WIDTH-1:0] out_data_q [$];
    attr_t                 out_attr_q [$];
    int                    ext_steps;
    logic [31:0]           rng_state;

    int data_errors;
    int attr_errors;
    int count_errors;
    int flag_errors;
    int other_errors;

    tb_clock #(.PERIOD_NS(40.0)) i_tb_clock (.clk);

    pu_net #(
        .DATA_WIDTH(DATA_WIDTH),
        .PROG_DEPTH(PROG_DEPTH)
    ) i_pu_net (
        .clk, .rst, .prog_we, .prog_addr, .prog_data, .start,
        .in_data, .in_attr, .in_take, .out_valid, .out_data, .out_attr,
        .busy, .done
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Random word folded into the signed range of the lower half
    function automatic logic [DATA_WIDTH-1:0] sign_extend_low(input logic [31:0] r);
        longint value;
        value = longint'($signed(r[half_width-1:0]));
        return DATA_WIDTH'(value);
    endfunction

    function automatic logic operand_in_range(input logic [DATA_WIDTH-1:0] a);
        return longint'($signed(a[half_width-1:0])) == longint'($signed(a));
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_product(
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        longint sa;
        longint sb;
        sa = longint'($signed(a[half_width-1:0]));
        sb = longint'($signed(b[half_width-1:0]));
        return DATA_WIDTH'(sa * sb);
    endfunction

    function automatic logic sum_overflows(
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        longint sum;
        longint max_value;
        max_value = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
        sum = longint'($signed(a)) + longint'($signed(b));
        return (sum > max_value) || (sum < -max_value - 1);
    endfunction

    function automatic instr_t make_instr(input src_e src, input dst_e dst, input logic sel,
                                          input logic [1:0] addr, input logic last);
        instr_t step;
        step.src  = src;
        step.dst  = dst;
        step.sel  = sel;
        step.addr = addr;
        step.last = last;
        return step;
    endfunction

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] expected);
        if (got !== expected) begin
            data_errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_attr(input string name, input attr_t got, input attr_t expected);
        if (got !== expected) begin
            attr_errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            count_errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            flag_errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic push_input(input logic [DATA_WIDTH-1:0] data, input attr_t attr);
        in_data_q.push_back(data);
        in_attr_q.push_back(attr);
    endtask

    task automatic load_program();
        ext_steps = 0;
        for (int i = 0; i < program_q.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= addr_width'(i);
            prog_data <= program_q[i];
            if (program_q[i].dst == dst_ext) begin
                ext_steps++;
            end
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // Starts the loaded program, feeds the input queue and collects results
    task automatic run_program();
        logic take;
        logic finished;
        int   in_idx;
        int   dones;
        int   valids;
        in_idx   = 0;
        dones    = 0;
        valids   = 0;
        finished = 1'b0;
        out_data_q.delete();
        out_attr_q.delete();
        @(posedge clk);
        in_data <= (in_data_q.size() > 0) ? in_data_q[0] : '0;
        in_attr <= (in_attr_q.size() > 0) ? in_attr_q[0] : '0;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!finished) begin
            @(negedge clk);
            take = in_take;
            if (out_valid) begin
                valids++;
                out_data_q.push_back(out_data);
                out_attr_q.push_back(out_attr);
            end
            if (done) begin
                dones++;
                finished = 1'b1;
            end
            @(posedge clk);
            if (take) begin
                if (in_idx >= in_data_q.size()) begin
                    other_errors++;
                    $display("Error: the program took more input words than were supplied");
                end
                in_idx++;
                if (in_idx < in_data_q.size()) begin
                    in_data <= in_data_q[in_idx];
                    in_attr <= in_attr_q[in_idx];
                end
            end
        end
        repeat (2) begin // No late pulses after done
            @(negedge clk);
            if (out_valid) valids++;
            if (done) dones++;
        end
        check_count("done pulses", dones, 1);
        check_count("out_valid pulses", valids, ext_steps);
        check_count("in_take pulses", in_idx, in_data_q.size());
        in_data_q.delete();
        in_attr_q.delete();
    endtask

    task automatic load_mult_program();
        program_q.delete();
        program_q.push_back(make_instr(src_ext, dst_mult, 1'b1, 2'd0, 1'b0));
        program_q.push_back(make_instr(src_ext, dst_mult, 1'b0, 2'd0, 1'b0)); // Sel falls here
        program_q.push_back(make_instr(src_none, dst_none, 1'b0, 2'd0, 1'b0));
        program_q.push_back(make_instr(src_none, dst_none, 1'b0, 2'd0, 1'b0));
        program_q.push_back(make_instr(src_mult, dst_ext, 1'b0, 2'd0, 1'b1));
        load_program();
    endtask

    task automatic load_accum_program();
        program_q.delete();
        program_q.push_back(make_instr(src_ext, dst_accum, 1'b0, 2'd0, 1'b0)); // Load
        program_q.push_back(make_instr(src_ext, dst_accum, 1'b1, 2'd0, 1'b0)); // Add
        program_q.push_back(make_instr(src_accum, dst_fram, 1'b0, 2'd2, 1'b0));
        program_q.push_back(make_instr(src_fram, dst_ext, 1'b0, 2'd2, 1'b1));
        load_program();
    endtask

    task automatic mult_case(input logic [DATA_WIDTH-1:0] a, input attr_t a_attr,
                             input logic [DATA_WIDTH-1:0] b, input attr_t b_attr,
                             input logic check_value);
        attr_t expected_attr;
        expected_attr = '0;
        expected_attr[attr_invalid_bit] = !operand_in_range(a) || !operand_in_range(b)
                                          || a_attr[attr_invalid_bit]
                                          || b_attr[attr_invalid_bit];
        push_input(a, a_attr);
        push_input(b, b_attr);
        run_program();
        if (out_data_q.size() > 0) begin
            if (check_value) begin
                check_data("out_data", out_data_q[0], expected_product(a, b));
            end
            check_attr("out_attr", out_attr_q[0], expected_attr);
        end
    endtask

    task automatic accum_case(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        attr_t expected_attr;
        expected_attr = '0;
        expected_attr[attr_invalid_bit] = sum_overflows(a, b);
        push_input(a, '0);
        push_input(b, '0);
        run_program();
        if (out_data_q.size() > 0) begin
            check_data("out_data", out_data_q[0], a + b);
            check_attr("out_attr", out_attr_q[0], expected_attr);
        end
    endtask

    task automatic idle_after_reset();
        repeat (5) begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_take", in_take, 1'b0);
        end
    endtask

    task automatic mult_in_range();
        load_mult_program();
        mult_case(32'h0000_1234, '0, 32'hffff_ff9c, '0, 1'b1);
        mult_case(32'hffff_8000, '0, 32'hffff_8000, '0, 1'b1); // Most negative squared
    endtask

    task automatic mult_invalid();
        attr_t flagged;
        flagged = '0;
        flagged[attr_invalid_bit] = 1'b1;
        load_mult_program();
        mult_case(32'h0001_0003, '0, 32'h0000_0005, '0, 1'b0);
        mult_case(32'h0000_0007, flagged, 32'h0000_0009, '0, 1'b1);
    endtask

    task automatic accum_through_fram();
        load_accum_program();
        accum_case(32'd1000, 32'd234);
        accum_case(32'h7fff_fff0, 32'h0000_0020);
    endtask

    task automatic mult_random();
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        load_mult_program();
        for (int n = 0; n < random_runs; n++) begin
            rng_state = xorshift32(rng_state);
            a = sign_extend_low(rng_state);
            rng_state = xorshift32(rng_state);
            b = sign_extend_low(rng_state);
            mult_case(a, '0, b, '0, 1'b1);
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        start        = 1'b0;
        in_data      = '0;
        in_attr      = '0;
        rng_state    = 32'hbd28_b6e7;
        data_errors  = 0;
        attr_errors  = 0;
        count_errors = 0;
        flag_errors  = 0;
        other_errors = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        mult_in_range();
        mult_invalid();
        accum_through_fram();
        mult_random();
        $display("Errors: data %0d, attr %0d, count %0d, flag %0d, other %0d",
                 data_errors, attr_errors, count_errors, flag_errors, other_errors);
        if (data_errors + attr_errors + count_errors + flag_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/pu_bus_pkg.sv
src/pu_ctrl_pkg.sv
src/pu_multiplier.sv
src/pu_accum.sv
src/pu_fram.sv
src/pu_sequencer.sv
src/pu_net.sv
test/tb_clock.sv
test/pu_net_tb.sv

// File: Bender.yml
package:
  name: pu_net

sources:
  - files:
      - src/pu_bus_pkg.sv
      - src/pu_ctrl_pkg.sv
      - src/pu_multiplier.sv
      - src/pu_accum.sv
      - src/pu_fram.sv
      - src/pu_sequencer.sv
      - src/pu_net.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/pu_net_tb.sv
